//--- flist.f
// packages first, header folder on the include path
+incdir+.
regs_pkg.sv
isa_pkg.sv
regfile_if.sv
pipe_stage.sv
op_decode.sv
alu_exec.sv
bank_regs.sv
core_top.sv
// testbench
tb_clock.sv
core_assert.sv
tb_core.sv

//--- Makefile
LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module tb_core -o tb_core

run: build
	-./obj_dir/tb_core > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "=== FAIL ===" $(LOG) || ! grep -q "=== PASS ===" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; fi

lint:
	verilator --lint-only --timing --assert -f flist.f --top-module tb_core

clean:
	rm -rf obj_dir $(LOG)

//--- tb_core.sv
// core testbench
`timescale 1ns/1ps
`default_nettype none

module tb_core;
    localparam int NUM_INSTR   = 400;
    localparam int DUMP_EVERY  = 50;
    localparam int WATCHDOG_NS = (NUM_INSTR * 2 + 9 * 83 + 100) * 4;

    logic        clk;
    logic        rst;
    logic        instr_valid;
    logic [31:0] instr;
    logic        done;
    logic        done_illegal;
    logic        zero_flag;
    logic        carry_flag;
    logic [7:0]  dmp_addr;
    logic [7:0]  dmp_dout;

    // model state in the dump map byte layout
    logic [7:0]  mdl_mem [0:79];
    logic [1:0]  mdl_rfp;
    // {illegal, zero, carry} per issued instruction
    logic [2:0]  exp_q [$];
    logic [2:0]  ret_exp;
    int          err_count;

    tb_clock u_clock (
        .clk (clk)
    );

    core_top dut0 (
        .clk          (clk),
        .rst          (rst),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .done         (done),
        .done_illegal (done_illegal),
        .zero_flag    (zero_flag),
        .carry_flag   (carry_flag),
        .dmp_addr     (dmp_addr),
        .dmp_dout     (dmp_dout)
    );

    task automatic report_error(input string line);
        err_count++;
        $display("%s", line);
        $display("=== FAIL ===");
        $fatal(1, "stopped at first error");
    endtask

    // general registers at bank*4 + r and pointers in slots 16..19
    function automatic int slot_index(input logic [3:0] code);
        logic [1:0] bank;
        bank = code[3] ? mdl_rfp - 2'd1 : mdl_rfp;
        if (code[2]) begin
            return 16 + int'(code[1:0]);
        end
        return int'(bank) * 4 + int'(code[1:0]);
    endfunction

    function automatic logic [31:0] read_reg(input int slot);
        return {mdl_mem[slot * 4 + 3], mdl_mem[slot * 4 + 2],
                mdl_mem[slot * 4 + 1], mdl_mem[slot * 4]};
    endfunction

    task automatic write_reg(input int slot, input logic [31:0] val, input int nbytes);
        for (int k = 0; k < nbytes; k++) begin
            mdl_mem[slot * 4 + k] = val[8 * k +: 8];
        end
    endtask

    task automatic model_reset();
        for (int i = 0; i < 80; i++) begin
            mdl_mem[i] = 8'h00;
        end
        mdl_rfp = 2'd0;
        // xsp comes out of reset at 0x100
        write_reg(19, 32'h0000_0100, 4);
    endtask

    // expected effect and flags of one instruction
    task automatic model_step(input logic [3:0] op, input logic [1:0] sz,
                              input logic [3:0] dst, input logic [3:0] src,
                              input logic [15:0] imm, output logic [2:0] flags);
        int          nb;
        int          ds;
        int          ss;
        logic [31:0] mask;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] opnd;
        logic [31:0] res;
        logic        wr;
        logic        zero;
        logic        carry;
        logic        illegal;
        nb   = (sz == 2'd0) ? 1 : ((sz == 2'd1) ? 2 : 4);
        mask = (nb == 4) ? 32'hffff_ffff : (32'h1 << (8 * nb)) - 32'h1;
        ds   = slot_index(dst);
        ss   = slot_index(src);
        a    = read_reg(ds);
        b    = read_reg(ss);
        opnd = (op == 4'd9 || op == 4'd10) ? 32'(nb) : b;
        wr   = (op >= 4'd1 && op <= 4'd7) || op == 4'd9 || op == 4'd10;
        res     = '0;
        zero    = 1'b0;
        carry   = 1'b0;
        illegal = 1'b0;
        case (op)
            4'd0: ;
            4'd1: res = {16'h0000, imm};
            4'd2: res = b;
            4'd3, 4'd9: res = a + opnd;
            4'd4, 4'd10: res = a - opnd;
            4'd5: res = a & b;
            4'd6: res = a | b;
            4'd7: res = a ^ b;
            4'd8: begin
                write_reg(ds, b, nb);
                write_reg(ss, a, nb);
            end
            4'd11: mdl_rfp = mdl_rfp + 2'd1;
            4'd12: mdl_rfp = mdl_rfp - 2'd1;
            4'd13: mdl_rfp = imm[1:0];
            default: illegal = 1'b1;
        endcase
        // carry out of the size msb or borrow for subtraction
        if (op == 4'd3 || op == 4'd9) begin
            carry = ({1'b0, a & mask} + {1'b0, opnd & mask}) > {1'b0, mask};
        end
        if (op == 4'd4 || op == 4'd10) begin
            carry = (a & mask) < (opnd & mask);
        end
        if (wr) begin
            write_reg(ds, res, nb);
            zero = (res & mask) == 32'h0;
        end
        flags = {illegal, zero, carry};
    endtask

    task automatic issue_one();
        logic [3:0]  op;
        logic [1:0]  sz;
        logic [3:0]  dst;
        logic [3:0]  src;
        logic [15:0] imm;
        logic [2:0]  flags;
        // extra weight on LDI keeps registers populated
        op  = ($urandom % 4 == 0) ? 4'd1 : 4'($urandom % 16);
        sz  = 2'($urandom % 3);
        dst = 4'($urandom);
        src = 4'($urandom);
        imm = ($urandom % 8 == 0) ? 16'h0000 : 16'($urandom);
        model_step(op, sz, dst, src, imm, flags);
        exp_q.push_back(flags);
        instr       = {op, sz, dst, src, 2'b00, imm};
        instr_valid = 1'b1;
        @(posedge clk);
        #1;
        instr_valid = 1'b0;
        if ($urandom % 4 == 0) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic drain_retire();
        while (exp_q.size() != 0) begin
            @(posedge clk);
            #1;
        end
    endtask

    // one address per cycle and its data after the next edge
    task automatic dump_check();
        logic [7:0] exp;
        for (int a = 0; a <= 8'h50; a++) begin
            dmp_addr = 8'(a);
            @(posedge clk);
            #1;
            exp = (a < 80) ? mdl_mem[a] : {6'd0, mdl_rfp};
            assert (dmp_dout == exp) else begin
                report_error($sformatf("MISMATCH at %0t: dump addr %02h got %02h expected %02h",
                                       $time, a, dmp_dout, exp));
            end
        end
    endtask

    // retire outputs are stable at the falling edge
    always @(negedge clk) begin
        if (!rst && done) begin
            assert (exp_q.size() != 0) else begin
                report_error($sformatf("done at %0t with no instruction outstanding", $time));
            end
            ret_exp = exp_q.pop_front();
            assert ({done_illegal, zero_flag, carry_flag} == ret_exp) else begin
                report_error($sformatf("MISMATCH at %0t: illegal/zero/carry got %03b expected %03b",
                                       $time, {done_illegal, zero_flag, carry_flag}, ret_exp));
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: run did not finish within %0d ns", WATCHDOG_NS);
        $display("=== FAIL ===");
        $fatal(1, "watchdog expired");
    end

    initial begin
        void'($urandom(32'hc7e36db6));
        err_count   = 0;
        rst         = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        dmp_addr    = '0;
        model_reset();
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        dump_check();
        for (int i = 0; i < NUM_INSTR; i++) begin
            issue_one();
            if ((i + 1) % DUMP_EVERY == 0) begin
                drain_retire();
                dump_check();
            end
        end
        drain_retire();
        if (err_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- core_assert.sv
// retire timing checks
`timescale 1ns/1ps
`default_nettype none

module core_assert (
    input logic clk,
    input logic rst,
    input logic instr_valid,
    input logic done,
    input logic done_illegal
);

    // issue sampled at one edge is seen as done two edges later
    a_done_follows: assert property (@(posedge clk) disable iff (rst)
        instr_valid |-> ##2 done)
        else $error("done missing two cycles after issue");

    a_done_source: assert property (@(posedge clk) disable iff (rst)
        done |-> $past(instr_valid, 2))
        else $error("done without an issue two cycles earlier");

    a_illegal_done: assert property (@(posedge clk) disable iff (rst)
        done_illegal |-> done)
        else $error("done_illegal raised without done");

endmodule

bind core_top core_assert u_core_assert (
    .clk          (clk),
    .rst          (rst),
    .instr_valid  (instr_valid),
    .done         (done),
    .done_illegal (done_illegal)
);

`default_nettype wire

//--- tb_clock.sv
// testbench clock source
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk
);

    // 4 ns period
    initial begin
        clk = 1'b0;
    end

    always #2 clk = ~clk;

endmodule

`default_nettype wire

//--- core_top.sv
// core top level
`timescale 1ns/1ps
`default_nettype none
`include "core_macros.svh"

module core_top (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     instr_valid,
    input  logic [`CORE_INSTR_W-1:0] instr,
    output logic                     done,
    output logic                     done_illegal,
    output logic                     zero_flag,
    output logic                     carry_flag,
    input  logic [7:0]               dmp_addr,
    output logic [7:0]               dmp_dout
);
    import isa_pkg::*;

    instr_t  instr_w;
    dec_op_t dec_c;
    dec_op_t dec_q;
    retire_t ret_c;
    retire_t ret_q;

    regfile_if rf ();

    assign instr_w = instr;

    op_decode u_decode (
        .instr_valid (instr_valid),
        .instr       (instr_w),
        .dec         (dec_c)
    );

    // decoded word, valid one cycle after issue
    pipe_stage #(.payload_t(dec_op_t)) u_dec_stage (
        .clk (clk),
        .rst (rst),
        .in  (dec_c),
        .out (dec_q)
    );

    alu_exec u_exec (
        .dec (dec_q),
        .rf  (rf.exec),
        .ret (ret_c)
    );

    // retire lands on the same edge as the writeback
    pipe_stage #(.payload_t(retire_t)) u_ret_stage (
        .clk (clk),
        .rst (rst),
        .in  (ret_c),
        .out (ret_q)
    );

    bank_regs u_regs (
        .clk      (clk),
        .rst      (rst),
        .rf       (rf.regs),
        .dmp_addr (dmp_addr),
        .dmp_dout (dmp_dout)
    );

    assign done         = ret_q.valid;
    assign done_illegal = ret_q.illegal;
    assign zero_flag    = ret_q.zero;
    assign carry_flag   = ret_q.carry;

endmodule

`default_nettype wire

//--- bank_regs.sv
// banked register file
`timescale 1ns/1ps
`default_nettype none
`include "core_macros.svh"

module bank_regs (
    input  logic       clk,
    input  logic       rst,
    regfile_if.regs    rf,
    input  logic [7:0] dmp_addr,
    output logic [7:0] dmp_dout
);
    import regs_pkg::*;

    localparam int          GEN_BYTES = `CORE_NBANKS * 16;
    localparam int          NBYTES    = GEN_BYTES + 16;
    localparam int          XSP_BASE  = GEN_BYTES + 12;
    localparam logic [31:0] XSP_INIT  = `CORE_XSP_RESET;

    // general bytes then pointer bytes, same layout as the dump map
    logic [7:0] regs_q [0:NBYTES-1];
    logic [1:0] rfp;
    logic [1:0] prev_bank;
    logic [4:0] src_slot;
    logic [4:0] dst_slot;
    logic [2:0] wr_step;

    // register code to 32-bit slot, four bytes each
    function automatic logic [4:0] slot_of(
        input reg_code_t  code,
        input logic [1:0] cur,
        input logic [1:0] prev
    );
        logic [1:0] bank;
        bank = code[3] ? prev : cur;
        if (code[2]) begin
            return {3'b100, code[1:0]};
        end
        return {1'b0, bank, code[1:0]};
    endfunction

    // both codes resolve against rfp before the write edge
    assign prev_bank = rfp - 2'd1;
    assign src_slot  = slot_of(rf.rd_src, rfp, prev_bank);
    assign dst_slot  = slot_of(rf.rd_dst, rfp, prev_bank);

    always_comb begin
        for (int k = 0; k < 4; k++) begin
            rf.src_val[8*k +: 8] = regs_q[{src_slot, 2'(k)}];
            rf.dst_val[8*k +: 8] = regs_q[{dst_slot, 2'(k)}];
        end
    end

    // number of bytes written, also the inc/dec step
    always_comb begin
        case (rf.wr_size)
            SZ_BYTE: wr_step = 3'd1;
            SZ_WORD: wr_step = 3'd2;
            default: wr_step = 3'd4;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < NBYTES; i++) begin
                regs_q[i] <= 8'h00;
            end
            for (int k = 0; k < 4; k++) begin
                regs_q[XSP_BASE + k] <= XSP_INIT[8*k +: 8];
            end
        end else begin
            for (int k = 0; k < 4; k++) begin
                if (rf.wr_en && k < int'(wr_step)) begin
                    regs_q[{dst_slot, 2'(k)}] <= rf.wr_val[8*k +: 8];
                end
                // exchange writes the old dst at the same size
                if (rf.swap_en && k < int'(wr_step)) begin
                    regs_q[{src_slot, 2'(k)}] <= rf.swap_val[8*k +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rfp <= 2'd0;
        end else begin
            case (rf.rfp_op)
                RFP_INC:  rfp <= rfp + 2'd1;
                RFP_DEC:  rfp <= rfp - 2'd1;
                RFP_LOAD: rfp <= rf.rfp_imm;
                default:  rfp <= rfp;
            endcase
        end
    end

    // registered dump port
    always_ff @(posedge clk) begin
        if (dmp_addr < 8'(NBYTES)) begin
            dmp_dout <= regs_q[dmp_addr[6:0]];
        end else if (dmp_addr == `CORE_DMP_RFP) begin
            dmp_dout <= {6'd0, rfp};
        end else begin
            dmp_dout <= 8'h00;
        end
    end

endmodule

`default_nettype wire

//--- alu_exec.sv
// execute stage with ALU and flags
`timescale 1ns/1ps
`default_nettype none

module alu_exec (
    input  isa_pkg::dec_op_t dec,
    regfile_if.exec          rf,
    output isa_pkg::retire_t ret
);
    import isa_pkg::*;
    import regs_pkg::*;

    logic [31:0] mask;
    logic [31:0] op_b;
    logic [31:0] a_m;
    logic [31:0] b_m;
    logic [32:0] arith;
    logic [31:0] result;
    logic        is_arith;
    logic        carry_out;

    always_comb begin
        case (dec.size)
            SZ_BYTE: mask = 32'h0000_00ff;
            SZ_WORD: mask = 32'h0000_ffff;
            default: mask = 32'hffff_ffff;
        endcase
    end

    // INC and DEC use the size step as second operand
    assign is_arith = dec.alu_fn inside {FN_ADD, FN_SUB, FN_ADD_STEP, FN_SUB_STEP};
    assign op_b = (dec.alu_fn inside {FN_ADD_STEP, FN_SUB_STEP}) ?
                  {29'd0, dec.step} : rf.src_val;
    assign a_m = rf.dst_val & mask;
    assign b_m = op_b & mask;

    // masked operands put carry or borrow just above the size msb
    always_comb begin
        arith = '0;
        case (dec.alu_fn)
            FN_PASS_SRC: result = rf.src_val;
            FN_PASS_IMM: result = {16'd0, dec.imm};
            FN_ADD, FN_ADD_STEP: begin
                arith  = {1'b0, a_m} + {1'b0, b_m};
                result = arith[31:0];
            end
            FN_SUB, FN_SUB_STEP: begin
                arith  = {1'b0, a_m} - {1'b0, b_m};
                result = arith[31:0];
            end
            FN_AND:  result = rf.dst_val & rf.src_val;
            FN_OR:   result = rf.dst_val | rf.src_val;
            FN_XOR:  result = rf.dst_val ^ rf.src_val;
            default: result = rf.src_val;
        endcase
    end

    always_comb begin
        case (dec.size)
            SZ_BYTE: carry_out = arith[8];
            SZ_WORD: carry_out = arith[16];
            default: carry_out = arith[32];
        endcase
    end

    assign rf.rd_src   = dec.src;
    assign rf.rd_dst   = dec.dst;
    assign rf.wr_en    = dec.wr_en;
    assign rf.wr_size  = dec.size;
    assign rf.wr_val   = result;
    assign rf.swap_en  = dec.swap_en;
    assign rf.swap_val = rf.dst_val;
    assign rf.rfp_op   = dec.rfp_op;
    assign rf.rfp_imm  = dec.imm[1:0];

    // zero only for ops with an ALU result, carry only for arithmetic
    always_comb begin
        ret.valid   = dec.valid;
        ret.illegal = dec.illegal;
        ret.zero    = dec.wr_en && !dec.swap_en && ((result & mask) == 32'd0);
        ret.carry   = is_arith && carry_out;
    end

endmodule

`default_nettype wire

//--- op_decode.sv
// instruction decoder
`timescale 1ns/1ps
`default_nettype none

module op_decode (
    input  logic             instr_valid,
    input  isa_pkg::instr_t  instr,
    output isa_pkg::dec_op_t dec
);
    import isa_pkg::*;
    import regs_pkg::*;

    always_comb begin
        dec = '0;
        if (instr_valid) begin
            dec.valid = 1'b1;
            dec.size  = instr.size;
            dec.dst   = instr.dst;
            dec.src   = instr.src;
            dec.imm   = instr.imm;
            case (instr.size)
                SZ_BYTE: dec.step = 3'd1;
                SZ_WORD: dec.step = 3'd2;
                default: dec.step = 3'd4;
            endcase
            case (instr.opcode)
                OP_NOP: ;
                OP_LDI: begin
                    dec.alu_fn = FN_PASS_IMM;
                    dec.wr_en  = 1'b1;
                end
                OP_MOV: begin
                    dec.alu_fn = FN_PASS_SRC;
                    dec.wr_en  = 1'b1;
                end
                OP_ADD: begin
                    dec.alu_fn = FN_ADD;
                    dec.wr_en  = 1'b1;
                end
                OP_SUB: begin
                    dec.alu_fn = FN_SUB;
                    dec.wr_en  = 1'b1;
                end
                OP_AND: begin
                    dec.alu_fn = FN_AND;
                    dec.wr_en  = 1'b1;
                end
                OP_OR: begin
                    dec.alu_fn = FN_OR;
                    dec.wr_en  = 1'b1;
                end
                OP_XOR: begin
                    dec.alu_fn = FN_XOR;
                    dec.wr_en  = 1'b1;
                end
                // src into dst, old dst back into src
                OP_EX: begin
                    dec.alu_fn  = FN_PASS_SRC;
                    dec.wr_en   = 1'b1;
                    dec.swap_en = 1'b1;
                end
                OP_INC: begin
                    dec.alu_fn = FN_ADD_STEP;
                    dec.wr_en  = 1'b1;
                end
                OP_DEC: begin
                    dec.alu_fn = FN_SUB_STEP;
                    dec.wr_en  = 1'b1;
                end
                OP_INCRFP: dec.rfp_op = RFP_INC;
                OP_DECRFP: dec.rfp_op = RFP_DEC;
                OP_LDRFP:  dec.rfp_op = RFP_LOAD;
                // codes 14 and 15 retire with no effect
                default:   dec.illegal = 1'b1;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- pipe_stage.sv
// generic pipeline register
`timescale 1ns/1ps
`default_nettype none

module pipe_stage #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  payload_t in,
    output payload_t out
);

    // all-zero payload means nothing in flight
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out <= '0;
        end else begin
            out <= in;
        end
    end

endmodule

`default_nettype wire

//--- regfile_if.sv
// execute to register file link
`timescale 1ns/1ps
`default_nettype none

interface regfile_if;
    import regs_pkg::*;

    reg_code_t   rd_src;
    reg_code_t   rd_dst;
    logic [31:0] src_val;
    logic [31:0] dst_val;
    logic        wr_en;
    op_size_t    wr_size;
    logic [31:0] wr_val;
    // old dst value going back to src on an exchange
    logic        swap_en;
    logic [31:0] swap_val;
    rfp_op_t     rfp_op;
    logic [1:0]  rfp_imm;

    modport exec (
        output rd_src, rd_dst, wr_en, wr_size, wr_val,
        output swap_en, swap_val, rfp_op, rfp_imm,
        input  src_val, dst_val
    );

    modport regs (
        input  rd_src, rd_dst, wr_en, wr_size, wr_val,
        input  swap_en, swap_val, rfp_op, rfp_imm,
        output src_val, dst_val
    );

endinterface

`default_nettype wire

//--- isa_pkg.sv
// instruction and retire types
`default_nettype none

package isa_pkg;

    // codes 14 and 15 are illegal
    typedef enum logic [3:0] {
        OP_NOP, OP_LDI, OP_MOV, OP_ADD, OP_SUB, OP_AND, OP_OR,
        OP_XOR, OP_EX, OP_INC, OP_DEC, OP_INCRFP, OP_DECRFP, OP_LDRFP
    } opcode_t;

    typedef struct packed {
        opcode_t              opcode;
        regs_pkg::op_size_t   size;
        regs_pkg::reg_code_t  dst;
        regs_pkg::reg_code_t  src;
        logic [1:0]           unused;
        logic [15:0]          imm;
    } instr_t;

    typedef enum logic [3:0] {
        FN_PASS_SRC, FN_PASS_IMM, FN_ADD, FN_SUB, FN_AND,
        FN_OR, FN_XOR, FN_ADD_STEP, FN_SUB_STEP
    } alu_fn_t;

    typedef struct packed {
        logic                 valid;
        logic                 illegal;
        alu_fn_t              alu_fn;
        regs_pkg::op_size_t   size;
        regs_pkg::reg_code_t  dst;
        regs_pkg::reg_code_t  src;
        logic [15:0]          imm;
        logic                 wr_en;
        logic                 swap_en;
        regs_pkg::rfp_op_t    rfp_op;
        // 1, 2 or 4 by size
        logic [2:0]           step;
    } dec_op_t;

    typedef struct packed {
        logic valid;
        logic illegal;
        logic zero;
        logic carry;
    } retire_t;

endpackage

`default_nettype wire

//--- regs_pkg.sv
// register file organization types
`default_nettype none

package regs_pkg;

    // bit 2 picks a pointer, bit 3 picks the previous bank
    typedef logic [3:0] reg_code_t;

    // operand size
    typedef enum logic [1:0] {
        SZ_BYTE = 2'd0,
        SZ_WORD = 2'd1,
        SZ_LONG = 2'd2
    } op_size_t;

    // register file pointer update
    typedef enum logic [1:0] {
        RFP_NONE = 2'd0,
        RFP_INC  = 2'd1,
        RFP_DEC  = 2'd2,
        RFP_LOAD = 2'd3
    } rfp_op_t;

endpackage

`default_nettype wire

//--- core_macros.svh
// core width and reset constants
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// instruction word width
`define CORE_INSTR_W 32

// number of general register banks
`define CORE_NBANKS 4

// stack pointer value out of reset
`define CORE_XSP_RESET 32'h0000_0100

// dump address that returns rfp
`define CORE_DMP_RFP 8'h50

`endif
